/* compile.f */
+incdir+tests
verilog/softmax_pkg.sv
verilog/recip_divider.sv
verilog/running_max.sv
verilog/exp_stage.sv
verilog/denom_unit.sv
verilog/normalize_mul.sv
verilog/softmax_top.sv
tests/tb_softmax.sv

/* run.sh */
#!/bin/sh
# build the softmax testbench with Verilator and run it from the project root.
cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal --top-module tb_softmax -f compile.f -o sim_tb &&
./obj_dir/sim_tb | tee /dev/stderr | grep -q "Regression passed" &&
echo "simulation status: ok" ||
{ echo "simulation status: failing"; exit 1; }

/* tests/softmax_model.svh */
/*
 * softmax reference model.
 * expected maximum, denominator and outputs, the stimulus LFSR and the compare tasks.
 */
`ifndef SOFTMAX_MODEL_SVH
`define SOFTMAX_MODEL_SVH

localparam longint unsigned DENOM_MASK = (64'd1 << ACC_WIDTH) - 1;

data_t           model_max;
logic            model_have_max;
longint unsigned model_denom;     // Q.15 sum of exponentials.
out_beat_t       want_q [$];      // expected output beats, in order.

// x^32 + x^22 + x^2 + x + 1.
function automatic logic [31:0] lfsr_step(logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

// 2^-(peak - x), lanes above the peak count as zero difference.
function automatic prob_t lane_exp(data_t peak, data_t x);
    int d;
    d = int'(peak) - int'(x);
    if (d < 0) begin
        d = 0;
    end
    return exp2_neg(diff_t'(d));
endfunction

task automatic model_clear();
    model_max      = '0;
    model_have_max = 1'b0;
    model_denom    = 0;
endtask

task automatic model_accumulate(in_beat_t b);
    data_t peak;
    logic  found;
    peak  = model_max;
    found = model_have_max;
    for (int i = 0; i < N_LANES; i++) begin
        if (b.strb[i] && (!found || $signed(b.data[i]) > peak)) begin
            peak = b.data[i];
        end
        found = found | b.strb[i];
    end
    if (model_have_max && peak > model_max) begin
        // maximum rose, scale the old sum down.
        model_denom = ((model_denom * lane_exp(peak, model_max)) >> 15) & DENOM_MASK;
    end
    for (int i = 0; i < N_LANES; i++) begin
        if (b.strb[i]) begin
            model_denom = (model_denom + lane_exp(peak, b.data[i])) & DENOM_MASK;
        end
    end
    model_max      = peak;
    model_have_max = found;
endtask

task automatic model_normalize(in_beat_t b);
    longint unsigned inv;
    longint unsigned p;
    out_beat_t       want;
    if (model_denom == 0) begin
        inv = 65535;
    end else begin
        inv = (64'd1 << 30) / model_denom;
    end
    if (inv > 65535) begin
        inv = 65535;
    end
    want.strb = b.strb;
    for (int i = 0; i < N_LANES; i++) begin
        p = 0;
        if (b.strb[i]) begin
            p = (longint'(lane_exp(model_max, b.data[i])) * inv) >> 15;
        end
        if (p > 65535) begin
            p = 65535;
        end
        want.prob[i] = prob_t'(p);
    end
    want_q.push_back(want);
endtask

task automatic check_beat(out_beat_t got, out_beat_t want);
    if (got !== want) begin
        stop_on_error($sformatf("output beat %h, expected %h", got, want));
    end
endtask

task automatic check_max(data_t got, data_t want);
    if (got !== want) begin
        stop_on_error($sformatf("max_o %h, expected %h", got, want));
    end
endtask

task automatic check_idle(logic busy);
    if (busy !== 1'b0) begin
        stop_on_error("busy_o still high with the datapath drained");
    end
endtask

`endif

/* tests/tb_softmax.sv */
/*
 * softmax testbench.
 * applies a table of beats through the datapath and checks outputs against a model.
 */
`timescale 1ns/10ps
`default_nettype none

module tb_softmax;
    import softmax_pkg::*;

    localparam int unsigned ACC_WIDTH = 24;
    localparam int          N_ENTRIES = 27;
    localparam int          TIMEOUT   = 60 * N_ENTRIES + 200;

    typedef struct packed {
        logic        clear;   // clear the datapath before this beat.
        mode_e       mode;
        strb_t       strb;
        logic [31:0] lanes;   // lane 3 in the top byte.
        logic        stall;   // random output ready.
    } stim_t;

    localparam stim_t STIM [N_ENTRIES] = '{
        // single softmax.
        '{1'b1, MODE_ACC,  4'hf, 32'h08_f0_10_00, 1'b0},
        '{1'b0, MODE_NORM, 4'hf, 32'h08_f0_10_00, 1'b0},
        // lanes 1 and 3 hold large unstrobed values.
        '{1'b1, MODE_ACC,  4'h5, 32'h70_20_70_e0, 1'b0},
        '{1'b0, MODE_NORM, 4'h5, 32'h70_20_70_e0, 1'b0},
        // rising maximum with far lanes underflowing.
        '{1'b1, MODE_ACC,  4'hf, 32'hc0_d0_e0_f0, 1'b0},
        '{1'b0, MODE_ACC,  4'hf, 32'h00_f8_e8_c0, 1'b0},
        '{1'b0, MODE_ACC,  4'hf, 32'h18_10_88_00, 1'b0},
        '{1'b0, MODE_ACC,  4'hf, 32'h30_20_80_10, 1'b0},
        '{1'b0, MODE_ACC,  4'hf, 32'h50_81_40_20, 1'b0},
        '{1'b0, MODE_ACC,  4'hf, 32'h7f_80_60_70, 1'b0},
        '{1'b0, MODE_NORM, 4'hf, 32'hc0_d0_e0_f0, 1'b0},
        '{1'b0, MODE_NORM, 4'hf, 32'h00_f8_e8_c0, 1'b0},
        '{1'b0, MODE_NORM, 4'hf, 32'h18_10_88_00, 1'b0},
        '{1'b0, MODE_NORM, 4'hf, 32'h30_20_80_10, 1'b0},
        '{1'b0, MODE_NORM, 4'hf, 32'h50_81_40_20, 1'b0},
        '{1'b0, MODE_NORM, 4'hf, 32'h7f_80_60_70, 1'b0},
        // back-pressure on the normalize pass.
        '{1'b1, MODE_ACC,  4'hf, 32'h08_f0_10_00, 1'b0},
        '{1'b0, MODE_ACC,  4'hf, 32'h20_30_e0_10, 1'b0},
        '{1'b0, MODE_NORM, 4'hf, 32'h08_f0_10_00, 1'b1},
        '{1'b0, MODE_NORM, 4'hf, 32'h20_30_e0_10, 1'b1},
        '{1'b0, MODE_NORM, 4'hf, 32'h08_f0_10_00, 1'b1},
        '{1'b0, MODE_NORM, 4'hf, 32'h20_30_e0_10, 1'b1},
        // two runs split by clear.
        '{1'b1, MODE_ACC,  4'h3, 32'h00_00_f4_1c, 1'b0},
        '{1'b0, MODE_NORM, 4'h3, 32'h00_00_f4_1c, 1'b0},
        '{1'b1, MODE_ACC,  4'hf, 32'h40_44_48_4c, 1'b0},
        '{1'b0, MODE_NORM, 4'hf, 32'h40_44_48_4c, 1'b1},
        '{1'b0, MODE_NORM, 4'hf, 32'h40_44_48_4c, 1'b1}
    };

    logic        clk_i = 1'b0;
    logic        rst_ni;
    logic        clear_i;
    logic        in_valid_i;
    logic        in_ready_o;
    in_beat_t    in_beat_i;
    logic        out_valid_o;
    logic        out_ready_i;
    out_beat_t   out_beat_o;
    data_t       max_o;
    logic        busy_o;
    logic        stall_en;
    logic        stall_now;
    logic [31:0] lfsr_q;
    int          cycle_cnt = 0;

    task automatic stop_on_error(string msg);
        $display("error at %0.1f ns: %s", $realtime, msg);
        $display("Regression failed");
        $fatal(1, "stopping at the first error");
    endtask

    `include "softmax_model.svh"

    softmax_top #(
        .ACC_WIDTH (ACC_WIDTH)
    ) dut (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .clear_i     (clear_i),
        .in_valid_i  (in_valid_i),
        .in_ready_o  (in_ready_o),
        .in_beat_i   (in_beat_i),
        .out_valid_o (out_valid_o),
        .out_ready_i (out_ready_i),
        .out_beat_o  (out_beat_o),
        .max_o       (max_o),
        .busy_o      (busy_o)
    );

    always #2 clk_i = ~clk_i;

    // output ready takes one LFSR bit per stalled cycle.
    always @(posedge clk_i) begin
        stall_now = stall_en;
        #0.5;
        if (stall_now) begin
            lfsr_q      = lfsr_step(lfsr_q);
            out_ready_i = lfsr_q[0];
        end else begin
            out_ready_i = 1'b1;
        end
    end

    // transfer happens on the next rising edge.
    always @(negedge clk_i) begin
        if (out_valid_o && out_ready_i) begin
            if (want_q.size() == 0) begin
                stop_on_error("output beat arrived with none expected");
            end else begin
                check_beat(out_beat_o, want_q.pop_front());
            end
        end
    end

    always @(posedge clk_i) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT) begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT);
            $display("Regression failed");
            $fatal(1, "simulation timed out");
        end
    end

    task automatic send_beat(in_beat_t beat);
        logic took;
        in_beat_i  = beat;
        in_valid_i = 1'b1;
        took       = 1'b0;
        while (!took) begin
            @(negedge clk_i);
            took = in_ready_o;
            @(posedge clk_i);
            #0.5;
        end
        in_valid_i = 1'b0;
    endtask

    task automatic clear_datapath();
        while (want_q.size() != 0 || busy_o) begin
            @(negedge clk_i);
        end
        @(posedge clk_i);
        #0.5;
        clear_i = 1'b1;
        @(posedge clk_i);
        #0.5;
        clear_i = 1'b0;
        model_clear();
    endtask

    task automatic finish_outputs();
        while (want_q.size() != 0) begin
            @(negedge clk_i);
        end
        @(posedge clk_i);
        #0.5;
        check_idle(busy_o);
    endtask

    initial begin
        stim_t    ent;
        in_beat_t beat;
        rst_ni      = 1'b0;
        clear_i     = 1'b0;
        in_valid_i  = 1'b0;
        in_beat_i   = '0;
        out_ready_i = 1'b1;
        stall_en    = 1'b0;
        lfsr_q      = 32'hb2df_12ec;
        model_clear();
        repeat (16) @(posedge clk_i);
        #0.5;
        rst_ni = 1'b1;
        if (!in_ready_o || out_valid_o) begin
            stop_on_error("handshake outputs not idle after reset");
        end
        check_idle(busy_o);
        for (int n = 0; n < N_ENTRIES; n++) begin
            ent = STIM[n];
            if (ent.clear) begin
                clear_datapath();
            end
            stall_en  = ent.stall;
            beat.mode = ent.mode;
            beat.strb = ent.strb;
            beat.data = ent.lanes;
            if (ent.mode == MODE_ACC) begin
                model_accumulate(beat);
                send_beat(beat);
                check_max(max_o, model_max);   // max stage has taken the beat.
            end else begin
                model_normalize(beat);
                send_beat(beat);
            end
        end
        stall_en = 1'b0;
        finish_outputs();
        $display("Regression passed");
        $finish;
    end

endmodule

`default_nettype wire

/* verilog/denom_unit.sv */
/*
 * denominator unit.
 * accumulates the rescaled exp sum and forwards normalize beats with 1/denominator.
 */
`timescale 1ns/10ps
`default_nettype none

module denom_unit #(
    parameter int unsigned ACC_WIDTH = 24
) (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  logic                   clear_i,
    input  logic                   valid_i,
    output logic                   ready_o,
    input  softmax_pkg::exp_beat_t beat_i,
    output logic                   valid_o,
    input  logic                   ready_i,
    output softmax_pkg::exp_beat_t beat_o,
    output softmax_pkg::prob_t     inv_o,
    output logic                   busy_o
);
    import softmax_pkg::*;

    localparam int unsigned PROD_WIDTH = ACC_WIDTH + 16;

    logic                  valid_q;
    exp_beat_t             beat_q;
    prob_t                 out_inv_q;
    logic                  recip_ok_q;
    logic [ACC_WIDTH-1:0]  denom_q;
    logic [ACC_WIDTH-1:0]  denom_d;
    logic [ACC_WIDTH-1:0]  lane_sum;
    logic [PROD_WIDTH-1:0] scaled;
    logic                  is_norm;
    logic                  out_free;
    logic                  recip_ready;
    logic                  acc_take;
    logic                  norm_take;
    logic                  div_start;
    logic                  div_done;
    logic                  div_busy;
    prob_t                 div_inv;

    assign is_norm     = beat_i.mode == MODE_NORM;
    assign out_free    = ~valid_q | ready_i;
    assign recip_ready = recip_ok_q | div_done;
    assign ready_o     = is_norm ? (out_free & recip_ready) : ~div_busy;
    assign acc_take    = valid_i & ~is_norm & ~div_busy;
    assign norm_take   = valid_i & is_norm & out_free & recip_ready;
    assign div_start   = valid_i & is_norm & ~recip_ok_q & ~div_busy;

    always_comb begin
        scaled   = PROD_WIDTH'(denom_q) * PROD_WIDTH'(beat_i.factor);
        lane_sum = '0;
        for (int i = 0; i < N_LANES; i++) begin
            lane_sum = lane_sum + ACC_WIDTH'(beat_i.lanes[i]);
        end
        denom_d = scaled[ACC_WIDTH+14:15] + lane_sum;   // rescale, then add.
    end

    recip_divider #(
        .ACC_WIDTH (ACC_WIDTH)
    ) i_recip_divider (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .clear_i (clear_i),
        .start_i (div_start),
        .denom_i (denom_q),
        .done_o  (div_done),
        .inv_o   (div_inv),
        .busy_o  (div_busy)
    );

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q    <= 1'b0;
            recip_ok_q <= 1'b0;
            denom_q    <= '0;
        end else if (clear_i) begin
            valid_q    <= 1'b0;
            recip_ok_q <= 1'b0;
            denom_q    <= '0;
        end else begin
            if (acc_take) begin
                denom_q    <= denom_d;
                recip_ok_q <= 1'b0;   // denominator moved so the reciprocal is stale.
            end else if (div_done) begin
                recip_ok_q <= 1'b1;
            end
            if (norm_take) begin
                valid_q <= 1'b1;
            end else if (ready_i) begin
                valid_q <= 1'b0;
            end
        end
    end

    // reciprocal travels with the beat as a new division may finish under a stall.
    always_ff @(posedge clk_i) begin
        if (norm_take) begin
            beat_q    <= beat_i;
            out_inv_q <= div_inv;
        end
    end

    assign valid_o = valid_q;
    assign beat_o  = beat_q;
    assign inv_o   = out_inv_q;
    assign busy_o  = valid_q | div_busy;

endmodule

`default_nettype wire

/* verilog/exp_stage.sv */
/*
 * exponential stage.
 * base-2 exponential of each lane against the maximum, plus the rescale factor.
 */
`timescale 1ns/10ps
`default_nettype none

module exp_stage (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  logic                   clear_i,
    input  logic                   valid_i,
    output logic                   ready_o,
    input  softmax_pkg::max_beat_t beat_i,
    output logic                   valid_o,
    input  logic                   ready_i,
    output softmax_pkg::exp_beat_t beat_o,
    output logic                   busy_o
);
    import softmax_pkg::*;

    logic              valid_q;
    exp_beat_t         beat_q;
    exp_beat_t         beat_d;
    logic signed [9:0] lane_diff;
    diff_t             lane_d;
    logic              accept;

    assign ready_o = ~valid_q | ready_i;
    assign accept  = valid_i & ready_o;

    always_comb begin
        beat_d.mode = beat_i.beat.mode;
        beat_d.strb = beat_i.beat.strb;
        for (int i = 0; i < N_LANES; i++) begin
            lane_diff = {{2{beat_i.max_val[7]}}, beat_i.max_val}
                      - {{2{beat_i.beat.data[i][7]}}, beat_i.beat.data[i]};
            lane_d = lane_diff[9] ? '0 : lane_diff[8:0];   // above max, clamp.
            beat_d.lanes[i] = beat_i.beat.strb[i] ? exp2_neg(lane_d) : '0;
        end
        beat_d.factor = beat_i.rescale ? exp2_neg(beat_i.diff) : 16'd32768;
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= 1'b0;
        end else if (clear_i) begin
            valid_q <= 1'b0;
        end else if (accept) begin
            valid_q <= 1'b1;
        end else if (ready_i) begin
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            beat_q <= beat_d;
        end
    end

    assign valid_o = valid_q;
    assign beat_o  = beat_q;
    assign busy_o  = valid_q;

endmodule

`default_nettype wire

/* verilog/normalize_mul.sv */
/*
 * normalize multiplier.
 * scales each lane by the reciprocal and registers the output beat.
 */
`timescale 1ns/10ps
`default_nettype none

module normalize_mul (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  logic                   clear_i,
    input  logic                   valid_i,
    output logic                   ready_o,
    input  softmax_pkg::exp_beat_t beat_i,
    input  softmax_pkg::prob_t     inv_i,
    output logic                   valid_o,
    input  logic                   ready_i,
    output softmax_pkg::out_beat_t beat_o,
    output logic                   busy_o
);
    import softmax_pkg::*;

    logic        valid_q;
    out_beat_t   beat_q;
    out_beat_t   beat_d;
    logic [31:0] prod;
    logic        accept;

    assign ready_o = ~valid_q | ready_i;
    assign accept  = valid_i & ready_o;

    always_comb begin
        beat_d.strb = beat_i.strb;
        for (int i = 0; i < N_LANES; i++) begin
            prod = beat_i.lanes[i] * inv_i;
            if (!beat_i.strb[i]) begin
                beat_d.prob[i] = '0;
            end else begin
                beat_d.prob[i] = prod[31] ? '1 : prod[30:15];   // saturate.
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= 1'b0;
        end else if (clear_i) begin
            valid_q <= 1'b0;
        end else if (accept) begin
            valid_q <= 1'b1;
        end else if (ready_i) begin
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            beat_q <= beat_d;
        end
    end

    assign valid_o = valid_q;
    assign beat_o  = beat_q;
    assign busy_o  = valid_q;

endmodule

`default_nettype wire

/* verilog/recip_divider.sv */
/*
 * reciprocal divider.
 * restoring division of 2^30 by the denominator, one quotient bit per cycle.
 */
`timescale 1ns/10ps
`default_nettype none

module recip_divider #(
    parameter int unsigned ACC_WIDTH = 24
) (
    input  logic                 clk_i,
    input  logic                 rst_ni,
    input  logic                 clear_i,
    input  logic                 start_i,
    input  logic [ACC_WIDTH-1:0] denom_i,
    output logic                 done_o,
    output softmax_pkg::prob_t   inv_o,
    output logic                 busy_o
);

    localparam int unsigned CNT_WIDTH = $clog2(ACC_WIDTH);
    // dividend bits above the quotient window seed the remainder.
    localparam logic [63:0]          DIVIDEND = 64'd1 << 30;
    localparam logic [ACC_WIDTH:0]   REM_INIT = (ACC_WIDTH + 1)'(DIVIDEND >> ACC_WIDTH);
    localparam logic [ACC_WIDTH-1:0] NUM_INIT = DIVIDEND[ACC_WIDTH-1:0];

    typedef enum logic [1:0] {
        IDLE,
        RUN,
        DONE
    } state_e;

    state_e               state_q;
    logic [CNT_WIDTH-1:0] cnt_q;
    logic [ACC_WIDTH-1:0] div_q;
    logic [ACC_WIDTH-1:0] num_q;    // dividend bits still to shift in.
    logic [ACC_WIDTH:0]   rem_q;
    logic [ACC_WIDTH-1:0] quot_q;
    logic                 ovf_q;    // quotient beyond the window.
    logic [ACC_WIDTH:0]   rem_shift;
    logic                 take;

    assign rem_shift = {rem_q[ACC_WIDTH-1:0], num_q[ACC_WIDTH-1]};
    assign take      = rem_shift >= {1'b0, div_q};

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= IDLE;
            cnt_q   <= '0;
        end else if (clear_i) begin
            state_q <= IDLE;
            cnt_q   <= '0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (start_i) begin
                        state_q <= RUN;
                        cnt_q   <= '0;
                    end
                end
                RUN: begin
                    cnt_q <= cnt_q + 1'b1;
                    if (cnt_q == CNT_WIDTH'(ACC_WIDTH - 1)) begin
                        state_q <= DONE;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == IDLE && start_i) begin
            div_q  <= denom_i;
            num_q  <= NUM_INIT;
            rem_q  <= REM_INIT;
            quot_q <= '0;
            ovf_q  <= (denom_i == '0) || (REM_INIT >= {1'b0, denom_i});   // zero saturates.
        end else if (state_q == RUN) begin
            rem_q  <= take ? rem_shift - {1'b0, div_q} : rem_shift;
            quot_q <= {quot_q[ACC_WIDTH-2:0], take};
            num_q  <= num_q << 1;
        end
    end

    assign inv_o  = (ovf_q || |quot_q[ACC_WIDTH-1:16]) ? '1 : quot_q[15:0];
    assign done_o = state_q == DONE;
    assign busy_o = state_q != IDLE;

endmodule

`default_nettype wire

/* verilog/running_max.sv */
/*
 * running maximum stage.
 * tracks the maximum over accumulate beats and tags each beat with the rise.
 */
`timescale 1ns/10ps
`default_nettype none

module running_max (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  logic                   clear_i,
    input  logic                   valid_i,
    output logic                   ready_o,
    input  softmax_pkg::in_beat_t  beat_i,
    output logic                   valid_o,
    input  logic                   ready_i,
    output softmax_pkg::max_beat_t beat_o,
    output softmax_pkg::data_t     max_o,
    output logic                   busy_o
);
    import softmax_pkg::*;

    logic      valid_q;
    max_beat_t beat_q;
    data_t     max_q;
    logic      have_max_q;
    data_t     max_d;
    diff_t     diff_d;
    logic      any_lane;
    logic      rises;
    logic      accept;

    assign ready_o = ~valid_q | ready_i;
    assign accept  = valid_i & ready_o;

    always_comb begin
        max_d    = max_q;
        any_lane = 1'b0;
        if (beat_i.mode == MODE_ACC) begin
            for (int i = 0; i < N_LANES; i++) begin
                if (beat_i.strb[i]) begin
                    // first strobed lane after clear seeds the maximum.
                    if ((!have_max_q && !any_lane) || $signed(beat_i.data[i]) > max_d) begin
                        max_d = beat_i.data[i];
                    end
                    any_lane = 1'b1;
                end
            end
        end
        rises  = have_max_q && any_lane && (max_d > max_q);
        diff_d = rises ? diff_t'({max_d[7], max_d} - {max_q[7], max_q}) : '0;
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q    <= 1'b0;
            max_q      <= '0;
            have_max_q <= 1'b0;
        end else if (clear_i) begin
            valid_q    <= 1'b0;
            max_q      <= '0;
            have_max_q <= 1'b0;
        end else begin
            if (accept) begin
                valid_q    <= 1'b1;
                max_q      <= max_d;   // unchanged for normalize beats.
                have_max_q <= have_max_q | any_lane;
            end else if (ready_i) begin
                valid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            beat_q.beat    <= beat_i;
            beat_q.max_val <= max_d;
            beat_q.diff    <= diff_d;
            beat_q.rescale <= rises;
        end
    end

    assign valid_o = valid_q;
    assign beat_o  = beat_q;
    assign max_o   = max_q;
    assign busy_o  = valid_q;

endmodule

`default_nettype wire

/* verilog/softmax_pkg.sv */
/*
 * softmax package.
 * widths, beat structs and the base-2 exponential shared by the datapath stages.
 */
`default_nettype none

package softmax_pkg;

    localparam int unsigned N_LANES = 4;

    typedef logic signed [7:0]  data_t;   // Q4.4, log2 units.
    typedef logic [8:0]         diff_t;   // Q5.4, never negative.
    typedef logic [15:0]        prob_t;   // Q0.15.
    typedef logic [N_LANES-1:0] strb_t;

    typedef enum logic {
        MODE_ACC  = 1'b0,
        MODE_NORM = 1'b1
    } mode_e;

    typedef struct packed {
        mode_e               mode;
        strb_t               strb;
        data_t [N_LANES-1:0] data;
    } in_beat_t;

    typedef struct packed {
        in_beat_t beat;
        data_t    max_val;
        diff_t    diff;      // rise of the maximum.
        logic     rescale;
    } max_beat_t;

    typedef struct packed {
        mode_e               mode;
        strb_t               strb;
        prob_t [N_LANES-1:0] lanes;
        prob_t               factor;   // denominator rescale, 32768 is x1.
    } exp_beat_t;

    typedef struct packed {
        strb_t               strb;
        prob_t [N_LANES-1:0] prob;
    } out_beat_t;

    // 2^(15 - f/16), first entry trimmed to fit Q0.15.
    localparam prob_t EXP_TABLE [16] = '{
        16'd32767, 16'd31379, 16'd30048, 16'd28774,
        16'd27554, 16'd26386, 16'd25268, 16'd24196,
        16'd23170, 16'd22188, 16'd21247, 16'd20347,
        16'd19484, 16'd18658, 16'd17867, 16'd17109
    };

    // 2^-d for d in Q5.4.
    function automatic prob_t exp2_neg(diff_t d);
        prob_t frac;
        frac = EXP_TABLE[d[3:0]];
        if (d[8:4] >= 5'd16) begin
            return '0;   // underflow.
        end
        return frac >> d[8:4];
    endfunction

endpackage

`default_nettype wire

/* verilog/softmax_top.sv */
/*
 * softmax top level.
 * max, exp, denominator and normalize stages chained by valid/ready streams.
 */
`timescale 1ns/10ps
`default_nettype none

module softmax_top #(
    parameter int unsigned ACC_WIDTH = 24
) (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  logic                   clear_i,
    input  logic                   in_valid_i,
    output logic                   in_ready_o,
    input  softmax_pkg::in_beat_t  in_beat_i,
    output logic                   out_valid_o,
    input  logic                   out_ready_i,
    output softmax_pkg::out_beat_t out_beat_o,
    output softmax_pkg::data_t     max_o,
    output logic                   busy_o
);
    import softmax_pkg::*;

    logic      max_valid;
    logic      max_ready;
    max_beat_t max_beat;
    logic      exp_valid;
    logic      exp_ready;
    exp_beat_t exp_beat;
    logic      norm_valid;
    logic      norm_ready;
    exp_beat_t norm_beat;
    prob_t     norm_inv;
    logic      max_busy;
    logic      exp_busy;
    logic      denom_busy;
    logic      mul_busy;

    running_max i_running_max (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .clear_i (clear_i),
        .valid_i (in_valid_i),
        .ready_o (in_ready_o),
        .beat_i  (in_beat_i),
        .valid_o (max_valid),
        .ready_i (max_ready),
        .beat_o  (max_beat),
        .max_o   (max_o),
        .busy_o  (max_busy)
    );

    exp_stage i_exp_stage (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .clear_i (clear_i),
        .valid_i (max_valid),
        .ready_o (max_ready),
        .beat_i  (max_beat),
        .valid_o (exp_valid),
        .ready_i (exp_ready),
        .beat_o  (exp_beat),
        .busy_o  (exp_busy)
    );

    denom_unit #(
        .ACC_WIDTH (ACC_WIDTH)
    ) i_denom_unit (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .clear_i (clear_i),
        .valid_i (exp_valid),
        .ready_o (exp_ready),
        .beat_i  (exp_beat),
        .valid_o (norm_valid),
        .ready_i (norm_ready),
        .beat_o  (norm_beat),
        .inv_o   (norm_inv),
        .busy_o  (denom_busy)
    );

    normalize_mul i_normalize_mul (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .clear_i (clear_i),
        .valid_i (norm_valid),
        .ready_o (norm_ready),
        .beat_i  (norm_beat),
        .inv_i   (norm_inv),
        .valid_o (out_valid_o),
        .ready_i (out_ready_i),
        .beat_o  (out_beat_o),
        .busy_o  (mul_busy)
    );

    assign busy_o = max_busy | exp_busy | denom_busy | mul_busy;

endmodule

`default_nettype wire
